//--- Makefile
# Verilator build and run of the register operand decoder testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module decodeTb -f project.f -o decodeSim
	./obj_dir/decodeSim > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "CHECKS FAILED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir $(LOG)

//--- bench/decodeBind_properties.sv
// ==============================
// Decoder pipeline properties
// Latency, exception and reset checks bound into the top level
// ==============================
`timescale 1ns/1ps
`default_nettype none

module decodeProperties (
	input wire logic clk,
	input wire logic arstN,
	input wire logic instrValid,
	input wire decodePkg::instr_t instr,
	input wire logic outValid,
	input wire decodePkg::pregNum_t rs1Phys,
	input wire logic exc
);

	import decodePkg::*;

	logic realInstr;

	// Prefixes are absorbed and never reach the output
	assign realInstr = instrValid && (instr[6:0] != OP_IMM);

	// Output is registered at edge n+2 and so first sampled at edge n+3
	latencyCheck: assert property (@(posedge clk) disable iff (!arstN)
		$past(realInstr, 3) |-> outValid)
	else
		$error("Decoded instruction did not reach the output on time");

	// A faulting source read never leaks a register number
	excCheck: assert property (@(posedge clk) disable iff (!arstN)
		exc |-> rs1Phys == '0)
	else
		$error("Exception raised with a nonzero rs1Phys");

	resetCheck: assert property (@(posedge clk)
		!arstN |-> !outValid && !exc)
	else
		$error("Output valid or exception high during reset");

endmodule

bind decodeTop decodeProperties u_props (
	.clk(clk),
	.arstN(arstN),
	.instrValid(instrValid),
	.instr(instr),
	.outValid(outValid),
	.rs1Phys(rs1Phys),
	.exc(exc)
);

`default_nettype wire

//--- bench/decodeStimulus.mem
// Digits: test, om, control (1 valid then random gap, 3 valid in a burst),
// instr (8), rs1Phys (2), rdPhys (2), rs1Zero (1), exc (1); test 0 ends the file
// Test 1: integer, float and store operands in user mode
10100003284030500
10100014508140A00
1010001F38C3F2700
1010000C4A40C0000
10100000DA0001B10
10100001109010200
1010001B00A1B0000
// Test 2: registers 28 to 31 in each mode, 27 stays unbanked
2010001FE04838000
2010001DF12818200
2110001FE04878400
2110001DF12858600
2210001FE048B8800
2210001DF12898A00
2310001FE048F8C00
2310001DF128D8E00
2310001BD041B1A00
// Test 3: prefix, tagged successor, then a normal decode
30100ABC001000000
30100005304000610
30100005304050600
30100000001000000
3010000920C002410
3010000218A020300
30300000001000000
30100007420000810
// Test 4: branch fields 0 and 7, other branch fields, MOV bank select
40100000010000010
40100007010000010
40100003010430000
4010001D010450000
40180406112260200
40180803092430100
40100406112060200
4018001D212810400
40180C02092000101
// Test 5: CSR sources by mode and MOVEMD overrides
5310000500D650000
53190C04492000901
5010000500D000001
50193C04492640900
5011201EF928A8B00
5110000500D000001
5210000500D000001
// Test 6: back-to-back stream in supervisor mode
6130001CE84848500
6130000110C212200
6130000300D000001
61300002010420000
61300000FA0008710
6130001E024860000
6130000537F000010
61300000001000000
61300004208000410
61300003184030300
// End of stimulus
00000000000000000

//--- bench/decodeTb.sv
// ==============================
// Decoder testbench
// Replays the stimulus file through the pipeline and checks
// every decoded result against the values stored with it
// ==============================
`timescale 1ns/1ps
`default_nettype none

module decodeTb;

	import decodePkg::*;

	localparam int STIM_DEPTH = 128;
	localparam int DRAIN_LIMIT = 20;

	// One expected result per decoded instruction
	typedef struct packed {
		pregNum_t rs1;
		pregNum_t rd;
		logic zero;
		logic exc;
	} expectRec_t;

	logic clk;
	logic arstN;
	logic instrValid;
	instr_t instr;
	opMode_t om;
	logic outValid;
	pregNum_t rs1Phys;
	pregNum_t rdPhys;
	logic rs1Zero;
	logic exc;

	// Test id, mode, control, instruction, rs1, rd, zero flag and exception per word
	logic [67:0] stim [0:STIM_DEPTH-1];
	expectRec_t expQ[$];
	integer seed;
	int testChecks;
	int testErrors;
	int totalChecks;
	int totalErrors;
	int testsRun;
	logic hung;

	decodeTop #(
		.bankedRegs(4)
	) u_dut (
		.clk(clk),
		.arstN(arstN),
		.instrValid(instrValid),
		.instr(instr),
		.om(om),
		.outValid(outValid),
		.rs1Phys(rs1Phys),
		.rdPhys(rdPhys),
		.rs1Zero(rs1Zero),
		.exc(exc)
	);

	// 40 ns clock
	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic string testName(input logic [3:0] id);
		case (id)
		4'd1: return "user mode operands";
		4'd2: return "banked integer registers";
		4'd3: return "immediate prefix";
		4'd4: return "branch and move sources";
		4'd5: return "system registers";
		4'd6: return "back-to-back stream";
		default: return "unnamed";
		endcase
	endfunction

	task automatic compareField(input string name, input logic [7:0] got,
		input logic [7:0] want);
		testChecks++;
		assert (got === want)
		else
		begin
			$display("Fail time=%0t signal=%s got=%h expected=%h", $time, name, got, want);
			testErrors++;
		end
	endtask

	// Outputs settle after the rising edge, so they are read here on the falling one
	task automatic checkOutputs();
		expectRec_t want;
		assert (outValid || !exc)
		else
		begin
			$display("Exception raised at %0t without a valid output", $time);
			testErrors++;
		end
		if (outValid)
		begin
			assert (expQ.size() != 0)
			else
			begin
				$display("Output valid at %0t with no instruction in flight", $time);
				testErrors++;
			end
			if (expQ.size() != 0)
			begin
				want = expQ.pop_front();
				compareField("rs1Phys", rs1Phys, want.rs1);
				compareField("rdPhys", rdPhys, want.rd);
				compareField("rs1Zero", {7'd0, rs1Zero}, {7'd0, want.zero});
				compareField("exc", {7'd0, exc}, {7'd0, want.exc});
			end
		end
	endtask

	// Advance one cycle and drop the strobe unless the caller raises it again
	task automatic tick();
		@(negedge clk);
		checkOutputs();
		instrValid = 1'b0;
	endtask

	task automatic drain(output logic timedOut);
		int waited;
		waited = 0;
		while (expQ.size() != 0 && waited < DRAIN_LIMIT)
		begin
			tick();
			waited++;
		end
		timedOut = (expQ.size() != 0);
		if (timedOut)
			$display("Timeout: %0d results still missing after %0d cycles", expQ.size(),
				DRAIN_LIMIT);
	endtask

	task automatic closeTest(input logic [3:0] id);
		$display("Test %0d (%s): %0d checks, %0d errors", id, testName(id), testChecks,
			testErrors);
		totalChecks += testChecks;
		totalErrors += testErrors;
		testsRun++;
		testChecks = 0;
		testErrors = 0;
	endtask

	// ==============================
	// Stimulus replay
	// ==============================
	initial
	begin
		logic [67:0] stimLine;
		logic [3:0] curTest;
		expectRec_t want;
		int idx;
		int gap;
		seed = 95;
		hung = 1'b0;
		testChecks = 0;
		testErrors = 0;
		totalChecks = 0;
		totalErrors = 0;
		testsRun = 0;
		arstN = 1'b0;
		instrValid = 1'b0;
		instr = '0;
		om = MODE_USER;
		curTest = 4'd0;
		$readmemh("bench/decodeStimulus.mem", stim);
		repeat (5) @(posedge clk);
		@(negedge clk);
		arstN = 1'b1;
		for (idx = 0; idx < STIM_DEPTH; idx++)
		begin
			stimLine = stim[idx];
			// Test id 0 or an unread word ends the stimulus
			if ($isunknown(stimLine[67:64]) || stimLine[67:64] == 4'd0)
				break;
			// om is read in the last stage, so a new mode waits for an empty pipeline
			if (stimLine[67:64] != curTest || stimLine[61:60] != om)
			begin
				drain(hung);
				if (hung)
					break;
				if (stimLine[67:64] != curTest && curTest != 4'd0)
					closeTest(curTest);
				curTest = stimLine[67:64];
				om = opMode_t'(stimLine[61:60]);
			end
			tick();
			instrValid = stimLine[56];
			instr = stimLine[55:24];
			// Prefixes leave no result behind
			if (stimLine[56] && stimLine[30:24] != OP_IMM)
			begin
				want.rs1 = stimLine[23:16];
				want.rd = stimLine[15:8];
				want.zero = stimLine[4];
				want.exc = stimLine[0];
				expQ.push_back(want);
			end
			// Control bit 1 marks a burst line with no idle cycles after it
			if (!stimLine[57])
			begin
				gap = $random(seed) & 3;
				repeat (gap) tick();
			end
		end
		if (!hung)
			drain(hung);
		// A few quiet cycles catch any output nobody asked for
		if (!hung)
			repeat (4) tick();
		if (curTest != 4'd0)
			closeTest(curTest);
		if (totalChecks == 0)
			$display("No result was checked because the stimulus gave no instruction");
		$display("Summary: %0d tests, %0d checks, %0d errors", testsRun, totalChecks,
			totalErrors);
		if (totalErrors == 0 && totalChecks != 0 && !hung)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- hw/decodePkg.sv
// ==============================
// Decoder shared definitions
// Opcodes, register numbers, operating modes, stage records
// and the instruction field accessors
// ==============================
`default_nettype none

package decodePkg;

	// Raw 32-bit instruction word
	typedef logic [31:0] instr_t;
	// Architectural register number, bank in the top two bits
	typedef logic [6:0] aregNum_t;
	// Physical register number after banking
	typedef logic [7:0] pregNum_t;
	// Register index inside one bank
	typedef logic [4:0] regIdx_t;
	// Branch register index, only eight of them exist
	typedef logic [2:0] brIdx_t;
	typedef logic [1:0] bank_t;

	localparam bank_t BANK_INT = 2'b00;
	localparam bank_t BANK_FLT = 2'b01;
	localparam bank_t BANK_BR = 2'b10;
	localparam bank_t BANK_SYS = 2'b11;

	// Banked integer registers start here in the physical file
	localparam pregNum_t BANKED_BASE = 8'd128;

	// ==============================
	// Opcodes and modes
	// ==============================
	typedef enum logic [6:0] {
		OP_NOP = 7'h00,
		OP_IMM = 7'h01,
		OP_ADD = 7'h04,
		OP_AND = 7'h08,
		OP_OR = 7'h09,
		OP_XOR = 7'h0A,
		OP_FLT = 7'h0C,
		OP_CSR = 7'h0D,
		OP_BCC = 7'h10,
		OP_MOV = 7'h12,
		OP_LOAD = 7'h20,
		OP_STORE = 7'h24
	} opcode_t;

	typedef enum logic [1:0] {
		MODE_USER = 2'd0,
		MODE_SUPER = 2'd1,
		MODE_HYPER = 2'd2,
		MODE_MACHINE = 2'd3
	} opMode_t;

	// Output of the prefix stage, 34 bits
	typedef struct packed {
		logic valid;
		instr_t instr;
		logic hasImma;
	} prefixOut_t;

	// Output of the field decode stage
	typedef struct packed {
		logic valid;
		instr_t instr;
		aregNum_t archRs1;
		aregNum_t archRd;
		logic rs1Zero;
	} fieldOut_t;

	// ==============================
	// Field accessors
	// ==============================
	// Codes outside the opcode list decode as a NOP
	function automatic opcode_t opcodeOf(input instr_t ir);
		case (ir[6:0])
		OP_IMM, OP_ADD, OP_AND, OP_OR, OP_XOR, OP_FLT,
		OP_CSR, OP_BCC, OP_MOV, OP_LOAD, OP_STORE:
			return opcode_t'(ir[6:0]);
		default:
			return OP_NOP;
		endcase
	endfunction

	function automatic regIdx_t rdField(input instr_t ir);
		return ir[11:7];
	endfunction

	function automatic regIdx_t rs1Field(input instr_t ir);
		return ir[16:12];
	endfunction

	// The branch register overlays the low bits of the Rs1 field
	function automatic brIdx_t brField(input instr_t ir);
		return ir[14:12];
	endfunction

	// MOV bank select flag and the bank it names
	function automatic logic movBankSel(input instr_t ir);
		return ir[31];
	endfunction

	function automatic bank_t movBank(input instr_t ir);
		return ir[23:22];
	endfunction

	// MOVEMD flag and the mode it forces
	function automatic logic moveMdFlag(input instr_t ir);
		return ir[28];
	endfunction

	function automatic opMode_t moveMdMode(input instr_t ir);
		return opMode_t'(ir[25:24]);
	endfunction

endpackage

`default_nettype wire

//--- hw/decodeTop.sv
// ==============================
// Register operand decoder
// Three-stage pipeline from raw instruction to physical registers
// ==============================
`timescale 1ns/1ps
`default_nettype none

module decodeTop #(
	parameter int bankedRegs = 4
) (
	input wire logic clk,
	input wire logic arstN,
	input wire logic instrValid,
	input wire decodePkg::instr_t instr,
	input wire decodePkg::opMode_t om,
	output logic outValid,
	output decodePkg::pregNum_t rs1Phys,
	output decodePkg::pregNum_t rdPhys,
	output logic rs1Zero,
	output logic exc
);

	import decodePkg::*;

	// Stage records between the pipeline registers
	prefixOut_t prefixBus;
	fieldOut_t fieldBus;

	// Stage one drops prefixes and tags their successor
	prefixStage u_prefix (
		.clk(clk),
		.arstN(arstN),
		.instrValid(instrValid),
		.instr(instr),
		.stageOut(prefixBus)
	);

	// Stage two pulls out the register fields
	regFieldDecode u_field (
		.clk(clk),
		.arstN(arstN),
		.stageIn(prefixBus),
		.stageOut(fieldBus)
	);

	// Stage three applies the mode banking
	regMapStage #(
		.bankedRegs(bankedRegs)
	) u_map (
		.clk(clk),
		.arstN(arstN),
		.om(om),
		.stageIn(fieldBus),
		.outValid(outValid),
		.rs1Phys(rs1Phys),
		.rdPhys(rdPhys),
		.rs1Zero(rs1Zero),
		.exc(exc)
	);

endmodule

`default_nettype wire

//--- hw/prefixStage.sv
// ==============================
// Prefix stage
// Registers incoming instructions, swallows immediate prefixes
// and tags the instruction that follows one
// ==============================
`timescale 1ns/1ps
`default_nettype none

module prefixStage (
	input wire logic clk,
	input wire logic arstN,
	input wire logic instrValid,
	input wire decodePkg::instr_t instr,
	output decodePkg::prefixOut_t stageOut
);

	import decodePkg::*;

	// Set by a prefix, consumed by the next real instruction
	logic pendingImma;
	logic validQ;
	instr_t instrQ;
	logic hasImmaQ;
	logic isPrefix;

	// Only the opcode matters for prefix detection
	assign isPrefix = (opcodeOf(instr) == OP_IMM);

	// Control state, cleared by reset
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			pendingImma <= 1'b0;
			validQ <= 1'b0;
		end
		else
		begin
			// A prefix never leaves the stage
			validQ <= instrValid && !isPrefix;
			if (instrValid)
				pendingImma <= isPrefix;
		end
	end

	// Payload follows the valid strobe only
	always_ff @(posedge clk)
	begin
		if (instrValid && !isPrefix)
		begin
			instrQ <= instr;
			// The pending flag carries over onto this instruction
			hasImmaQ <= pendingImma;
		end
	end

	assign stageOut.valid = validQ;
	assign stageOut.instr = instrQ;
	assign stageOut.hasImma = hasImmaQ;

endmodule

`default_nettype wire

//--- hw/regFieldDecode.sv
// ==============================
// Register field decode stage
// Extracts architectural Rs1 and Rd by opcode class
// and flags a zero source register
// ==============================
`timescale 1ns/1ps
`default_nettype none

module regFieldDecode (
	input wire logic clk,
	input wire logic arstN,
	input wire decodePkg::prefixOut_t stageIn,
	output decodePkg::fieldOut_t stageOut
);

	import decodePkg::*;

	opcode_t op;
	regIdx_t rs1Idx;
	regIdx_t rdIdx;
	brIdx_t brIdx;
	aregNum_t archRs1;
	aregNum_t archRd;

	logic validQ;
	instr_t instrQ;
	aregNum_t rs1Q;
	aregNum_t rdQ;
	logic rs1ZeroQ;

	assign op = opcodeOf(stageIn.instr);
	assign rs1Idx = rs1Field(stageIn.instr);
	assign rdIdx = rdField(stageIn.instr);
	assign brIdx = brField(stageIn.instr);

	// ==============================
	// Source register
	// ==============================
	always_comb
	begin
		archRs1 = '0;
		// With an immediate attached the Rs1 slot holds immediate bits
		if (!stageIn.hasImma)
		begin
			case (op)
			OP_ADD, OP_AND, OP_OR, OP_XOR, OP_LOAD, OP_STORE:
				archRs1 = {BANK_INT, rs1Idx};
			OP_FLT:
				archRs1 = {BANK_FLT, rs1Idx};
			OP_CSR:
				archRs1 = {BANK_SYS, rs1Idx};
			OP_BCC:
				// Branch registers 0 and 7 are hardwired, no read needed
				if (brIdx != 3'd0 && brIdx != 3'd7)
					archRs1 = {BANK_BR, 2'b00, brIdx};
			OP_MOV:
				// A MOV may reach into any bank when bit 31 is set
				if (movBankSel(stageIn.instr))
					archRs1 = {movBank(stageIn.instr), rs1Idx};
				else
					archRs1 = {BANK_INT, rs1Idx};
			default:
				archRs1 = '0;
			endcase
		end
	end

	// ==============================
	// Destination register
	// ==============================
	always_comb
	begin
		case (op)
		OP_ADD, OP_AND, OP_OR, OP_XOR, OP_LOAD, OP_MOV:
			archRd = {BANK_INT, rdIdx};
		OP_FLT:
			archRd = {BANK_FLT, rdIdx};
		// Stores, branches and CSR ops write no register here
		default:
			archRd = '0;
		endcase
	end

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			validQ <= 1'b0;
		else
			validQ <= stageIn.valid;
	end

	always_ff @(posedge clk)
	begin
		if (stageIn.valid)
		begin
			instrQ <= stageIn.instr;
			rs1Q <= archRs1;
			rdQ <= archRd;
			rs1ZeroQ <= (archRs1 == '0);
		end
	end

	assign stageOut.valid = validQ;
	assign stageOut.instr = instrQ;
	assign stageOut.archRs1 = rs1Q;
	assign stageOut.archRd = rdQ;
	assign stageOut.rs1Zero = rs1ZeroQ;

endmodule

`default_nettype wire

//--- hw/regMapStage.sv
// ==============================
// Register map stage
// Maps architectural registers to physical numbers by mode
// and flags system registers used below machine mode
// ==============================
`timescale 1ns/1ps
`default_nettype none

module regMapStage #(
	parameter int bankedRegs = 4
) (
	input wire logic clk,
	input wire logic arstN,
	input wire decodePkg::opMode_t om,
	input wire decodePkg::fieldOut_t stageIn,
	output logic outValid,
	output decodePkg::pregNum_t rs1Phys,
	output decodePkg::pregNum_t rdPhys,
	output logic rs1Zero,
	output logic exc
);

	import decodePkg::*;

	// First integer register that has a copy per mode
	localparam int bankedFirst = 32 - bankedRegs;

	opMode_t effMode;
	pregNum_t rs1Map;
	pregNum_t rdMap;
	logic rs1Fault;
	logic rdFault;

	// One map serves both operands so they always agree on banking
	function automatic pregNum_t mapReg(input aregNum_t r, input opMode_t mode,
		output logic fault);
		int slot;
		fault = 1'b0;
		slot = int'(BANKED_BASE) + int'(mode) * bankedRegs + int'(r[4:0]) - bankedFirst;
		if (r[6:5] == BANK_INT && int'(r[4:0]) >= bankedFirst)
			return pregNum_t'(slot);
		if (r[6:5] == BANK_SYS && mode != MODE_MACHINE)
		begin
			// System registers are reachable from machine mode only
			fault = 1'b1;
			return '0;
		end
		return {1'b0, r};
	endfunction

	always_comb
	begin
		// MOVEMD runs its operands in the mode it names
		effMode = om;
		if (opcodeOf(stageIn.instr) == OP_MOV && moveMdFlag(stageIn.instr))
			effMode = moveMdMode(stageIn.instr);
		rs1Map = mapReg(stageIn.archRs1, effMode, rs1Fault);
		rdMap = mapReg(stageIn.archRd, effMode, rdFault);
	end

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			outValid <= 1'b0;
			exc <= 1'b0;
		end
		else
		begin
			outValid <= stageIn.valid;
			exc <= stageIn.valid && (rs1Fault || rdFault);
		end
	end

	always_ff @(posedge clk)
	begin
		if (stageIn.valid)
		begin
			rs1Phys <= rs1Map;
			rdPhys <= rdMap;
			rs1Zero <= stageIn.rs1Zero;
		end
	end

endmodule

`default_nettype wire

//--- project.f
hw/decodePkg.sv
hw/prefixStage.sv
hw/regFieldDecode.sv
hw/regMapStage.sv
hw/decodeTop.sv
bench/decodeBind_properties.sv
bench/decodeTb.sv
